//--- Bender.yml
package:
  name: sd_init

sources:
  - src/sd_init_pkg.sv
  - src/sd_clk_gen.sv
  - src/crc7_serial.sv
  - src/sd_cmd_tx.sv
  - src/sd_resp_rx.sv
  - src/sd_init_seq.sv
  - src/sd_init_top.sv
  - target: test
    files:
      - verification/sd_init_chk.sv
      - verification/sd_init_monitor.sv
      - verification/tb_sd_init.sv

//--- src.f
src/sd_init_pkg.sv
src/sd_clk_gen.sv
src/crc7_serial.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_init_seq.sv
src/sd_init_top.sv
verification/sd_init_chk.sv
verification/sd_init_monitor.sv
verification/tb_sd_init.sv

//--- src/crc7_serial.sv
/*
 * Bit-serial CRC7 over the leading 40 bits of a command frame
 * One bit per CLK, result valid with crc_done
 */
`timescale 1ns/10ps

module crc7_serial (
    input  logic                CLK,
    input  logic                rst,
    input  logic                crc_start,
    input  sd_init_pkg::frame_t crc_frame,
    output logic                crc_done,
    output logic [6:0]          crc
);

    logic [sd_init_pkg::crc_data_w-1:0] data_sr;  // Bits still to be folded in, MSB first
    logic [5:0]                         bits_left; // Zero when idle

    // One LFSR step, feedback is register MSB xor incoming bit
    function automatic logic [6:0] crc_step(input logic [6:0] c, input logic b);
        logic fb;
        fb = c[6] ^ b;
        return {c[5:0], 1'b0} ^ (fb ? sd_init_pkg::crc7_poly : 7'd0);
    endfunction

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            bits_left <= '0;
            crc_done  <= 1'b0;
        end
        else
        begin
            crc_done <= 1'b0;
            if (crc_start)
            begin
                bits_left <= 6'(sd_init_pkg::crc_data_w - 1); // Start bit folded in on load
            end
            else if (bits_left != '0)
            begin
                bits_left <= bits_left - 1'b1;
                crc_done  <= (bits_left == 6'd1); // 40th bit goes in now
            end
        end
    end

    // Payload path
    always_ff @(posedge CLK)
    begin
        if (crc_start)
        begin
            crc     <= crc_step(7'd0, crc_frame[47]);
            data_sr <= {crc_frame[46:8], 1'b0};
        end
        else if (bits_left != '0)
        begin
            crc     <= crc_step(crc, data_sr[sd_init_pkg::crc_data_w-1]);
            data_sr <= data_sr << 1;
        end
    end

endmodule

//--- src/sd_clk_gen.sv
/*
 * SD clock divider with single-cycle rise and fall strobes
 */
`timescale 1ns/10ps

module sd_clk_gen #(
    parameter int half_div = 60                  // CLK cycles per half period
) (
    input  logic CLK,
    input  logic rst,
    output logic sd_clk,
    output logic sd_rise,
    output logic sd_fall
);

    localparam int cnt_w = $clog2(half_div + 1);

    logic [cnt_w-1:0] div_cnt;                   // Half period counter
    logic             half_end;                  // Last cycle of a half period

    assign half_end = (div_cnt == cnt_w'(half_div - 1));

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;                     // Card clock idles low
            sd_rise <= 1'b0;
            sd_fall <= 1'b0;
        end
        else
        begin
            sd_rise <= half_end && !sd_clk;      // Aligned with sd_clk going high
            sd_fall <= half_end && sd_clk;       // Aligned with sd_clk going low
            if (half_end)
            begin
                div_cnt <= '0;
                sd_clk  <= ~sd_clk;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- src/sd_cmd_tx.sv
/*
 * Command frame transmitter on the CMD line
 * Shifts MSB first on SD clock falls, owns cmd_out and cmd_oe
 */
`timescale 1ns/10ps

module sd_cmd_tx (
    input  logic                CLK,
    input  logic                rst,
    input  logic                sd_rise,
    input  logic                sd_fall,
    input  logic                tx_start,
    input  sd_init_pkg::frame_t tx_frame,
    input  logic                line_release,  // Response window from sequencer
    output logic                cmd_out,
    output logic                cmd_oe,
    output logic                tx_done
);

    sd_init_pkg::frame_t tx_sr;                 // Frame shifter
    logic [5:0]          bits_left;             // Bits not yet on the line
    logic                busy;

    // Card samples bit 0 on this rise
    assign tx_done = busy && sd_rise && (bits_left == '0);

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            bits_left <= '0;
            cmd_out   <= 1'b1;                  // Idle high
            cmd_oe    <= 1'b1;
        end
        else
        begin
            cmd_oe <= !(tx_done || line_release); // Hand CMD to card after last bit
            if (tx_start)
            begin
                busy      <= 1'b1;
                bits_left <= 6'(sd_init_pkg::frame_w);
            end
            else if (busy && sd_fall && bits_left != '0)
            begin
                cmd_out   <= tx_sr[sd_init_pkg::frame_w-1];
                bits_left <= bits_left - 1'b1;
            end
            else if (tx_done)
                busy <= 1'b0;
            if (line_release)
                cmd_out <= 1'b1;                // Back to idle level for next command
        end
    end

    always_ff @(posedge CLK)
    begin
        if (tx_start)
            tx_sr <= tx_frame;
        else if (busy && sd_fall && bits_left != '0)
            tx_sr <= {tx_sr[sd_init_pkg::frame_w-2:0], 1'b1};
    end

endmodule

//--- src/sd_init_pkg.sv
/*
 * Shared widths, frame types and CRC7 generator for SD card bring-up
 * Fixed command frames for CMD0, CMD8, CMD55 and ACMD41
 */
package sd_init_pkg;

    localparam int frame_w    = 48;              // Command and response frame
    localparam int crc_data_w = 40;              // Start, dir, index, argument

    typedef logic [frame_w-1:0] frame_t;
    typedef logic [31:0]        ocr_t;

    // Frame layout {start, dir, index[5:0], arg[31:0], crc[6:0], end}
    // CRC field is left zero and filled in by the sequencer
    localparam frame_t cmd0_frame   = {2'b01, 6'd0,  32'h0000_0000, 7'h00, 1'b1}; // GO_IDLE_STATE
    localparam frame_t cmd8_frame   = {2'b01, 6'd8,  32'h0000_01AA, 7'h00, 1'b1}; // SEND_IF_COND
    localparam frame_t cmd55_frame  = {2'b01, 6'd55, 32'h0000_0000, 7'h00, 1'b1}; // APP_CMD
    localparam frame_t acmd41_frame = {2'b01, 6'd41, 32'h4010_0000, 7'h00, 1'b1}; // HCS, 3.3 V window

    localparam logic [6:0] crc7_poly = 7'h09;    // x^7 + x^3 + 1

    localparam int ready_bit   = 39;             // Busy/ready flag in R3 frame
    localparam int init_clocks = 80;             // Idle clocks before CMD0

endpackage

//--- src/sd_init_seq.sv
/*
 * Card init sequencer: power-up delay, then CMD0, CMD8 and CMD55/ACMD41 loop
 * Holds init_done and the OCR from the ready ACMD41 response
 */
`timescale 1ns/10ps

module sd_init_seq (
    input  logic                CLK,
    input  logic                rst,
    input  logic                sd_rise,
    input  logic                crc_done,
    input  logic [6:0]          crc,
    input  logic                tx_done,
    input  logic                rx_done,
    input  logic                rx_timeout,
    input  sd_init_pkg::frame_t resp,
    output logic                crc_start,
    output sd_init_pkg::frame_t crc_frame,
    output logic                tx_start,
    output sd_init_pkg::frame_t tx_frame,
    output logic                line_release,
    output logic                rx_start,
    output logic                init_done,
    output sd_init_pkg::ocr_t   ocr
);

    localparam int dly_w = $clog2(sd_init_pkg::init_clocks + 1);

    typedef enum logic [2:0] {s_delay, s_pick, s_crc, s_send, s_listen, s_done} state_t;
    typedef enum logic [1:0] {sel_cmd0, sel_cmd8, sel_cmd55, sel_acmd41} cmd_sel_t;

    state_t              state;
    cmd_sel_t            cmd_sel;               // Command being issued
    logic [dly_w-1:0]    delay_cnt;             // Idle SD clocks so far
    sd_init_pkg::frame_t cur_frame;             // Frame without CRC

    assign crc_frame = cur_frame;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state        <= s_delay;
            cmd_sel      <= sel_cmd0;
            delay_cnt    <= '0;
            crc_start    <= 1'b0;
            tx_start     <= 1'b0;
            rx_start     <= 1'b0;
            line_release <= 1'b0;
            init_done    <= 1'b0;
            ocr          <= '0;
        end
        else
        begin
            crc_start <= 1'b0;
            tx_start  <= 1'b0;
            rx_start  <= 1'b0;
            case (state)
                s_delay:                        // CMD idles high, clock runs
                begin
                    if (sd_rise)
                    begin
                        if (delay_cnt == dly_w'(sd_init_pkg::init_clocks - 1))
                            state <= s_pick;
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                s_pick:
                begin
                    crc_start <= 1'b1;
                    state     <= s_crc;
                end
                s_crc:
                begin
                    if (crc_done)
                    begin
                        tx_start <= 1'b1;
                        state    <= s_send;
                    end
                end
                s_send:
                begin
                    if (tx_done)
                    begin
                        line_release <= 1'b1;   // Card owns CMD now
                        rx_start     <= 1'b1;
                        state        <= s_listen;
                    end
                end
                s_listen:
                begin
                    if (rx_done || rx_timeout)
                    begin
                        line_release <= 1'b0;
                        state        <= s_pick;
                        case (cmd_sel)
                            sel_cmd0:   cmd_sel <= sel_cmd8;  // CMD0 never answers
                            sel_cmd8:   cmd_sel <= sel_cmd55;
                            sel_cmd55:  cmd_sel <= sel_acmd41;
                            default:    cmd_sel <= sel_cmd55; // Busy or silent, retry
                        endcase
                        if (cmd_sel == sel_acmd41 && rx_done && resp[sd_init_pkg::ready_bit])
                        begin
                            init_done <= 1'b1;
                            ocr       <= resp[39:8];
                            state     <= s_done;
                        end
                    end
                end
                default: state <= s_done;       // Init finished, no more commands
            endcase
        end
    end

    // Frame payload, latched when a command is picked and when its CRC arrives
    always_ff @(posedge CLK)
    begin
        if (state == s_pick)
        begin
            case (cmd_sel)
                sel_cmd0:  cur_frame <= sd_init_pkg::cmd0_frame;
                sel_cmd8:  cur_frame <= sd_init_pkg::cmd8_frame;
                sel_cmd55: cur_frame <= sd_init_pkg::cmd55_frame;
                default:   cur_frame <= sd_init_pkg::acmd41_frame;
            endcase
        end
        if (state == s_crc && crc_done)
            tx_frame <= {cur_frame[47:8], crc, cur_frame[0]};
    end

endmodule

//--- src/sd_init_top.sv
/*
 * SD bus-mode card init, top level
 * Clock divider, CRC7, CMD transmitter, response receiver, sequencer
 */
`timescale 1ns/10ps

module sd_init_top #(
    parameter int half_div     = 60,
    parameter int resp_timeout = 64
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              cmd_in,           // From CMD pad input buffer
    output logic              sd_clk,
    output logic              cmd_out,
    output logic              cmd_oe,           // High when host drives CMD
    output logic              init_done,
    output sd_init_pkg::ocr_t ocr
);

    logic                sd_rise;
    logic                sd_fall;
    logic                crc_start;
    logic                crc_done;
    logic [6:0]          crc;
    sd_init_pkg::frame_t crc_frame;
    logic                tx_start;
    logic                tx_done;
    sd_init_pkg::frame_t tx_frame;
    logic                line_release;
    logic                rx_start;
    logic                rx_done;
    logic                rx_timeout;
    sd_init_pkg::frame_t resp;

    sd_clk_gen #(.half_div(half_div)) i_sd_clk_gen (
        .CLK(CLK), .rst(rst), .sd_clk(sd_clk), .sd_rise(sd_rise), .sd_fall(sd_fall)
    );

    crc7_serial i_crc7_serial (
        .CLK(CLK), .rst(rst), .crc_start(crc_start), .crc_frame(crc_frame),
        .crc_done(crc_done), .crc(crc)
    );

    sd_cmd_tx i_sd_cmd_tx (
        .CLK(CLK), .rst(rst), .sd_rise(sd_rise), .sd_fall(sd_fall),
        .tx_start(tx_start), .tx_frame(tx_frame), .line_release(line_release),
        .cmd_out(cmd_out), .cmd_oe(cmd_oe), .tx_done(tx_done)
    );

    sd_resp_rx #(.resp_timeout(resp_timeout)) i_sd_resp_rx (
        .CLK(CLK), .rst(rst), .sd_rise(sd_rise), .rx_start(rx_start), .cmd_in(cmd_in),
        .rx_done(rx_done), .rx_timeout(rx_timeout), .resp(resp)
    );

    sd_init_seq i_sd_init_seq (
        .CLK(CLK), .rst(rst), .sd_rise(sd_rise), .crc_done(crc_done), .crc(crc),
        .tx_done(tx_done), .rx_done(rx_done), .rx_timeout(rx_timeout), .resp(resp),
        .crc_start(crc_start), .crc_frame(crc_frame), .tx_start(tx_start),
        .tx_frame(tx_frame), .line_release(line_release), .rx_start(rx_start),
        .init_done(init_done), .ocr(ocr)
    );

endmodule

//--- src/sd_resp_rx.sv
/*
 * Response receiver, hunts for start bit with a timeout
 * Captures 48 bits on SD clock rises
 */
`timescale 1ns/10ps

module sd_resp_rx #(
    parameter int resp_timeout = 64             // Rises allowed before start bit
) (
    input  logic                CLK,
    input  logic                rst,
    input  logic                sd_rise,
    input  logic                rx_start,
    input  logic                cmd_in,
    output logic                rx_done,
    output logic                rx_timeout,
    output sd_init_pkg::frame_t resp
);

    localparam int wait_w = $clog2(resp_timeout + 1);

    logic              hunting;                 // Waiting for start bit
    logic              capturing;               // Shifting in frame body
    logic [wait_w-1:0] wait_cnt;
    logic [5:0]        bits_left;               // Body bits still expected

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            hunting    <= 1'b0;
            capturing  <= 1'b0;
            wait_cnt   <= '0;
            bits_left  <= '0;
            rx_done    <= 1'b0;
            rx_timeout <= 1'b0;
        end
        else
        begin
            rx_done    <= 1'b0;
            rx_timeout <= 1'b0;
            if (rx_start)
            begin
                hunting  <= 1'b1;
                wait_cnt <= '0;
            end
            else if (hunting && sd_rise)
            begin
                if (!cmd_in)                    // Start bit is frame bit 47
                begin
                    hunting   <= 1'b0;
                    capturing <= 1'b1;
                    bits_left <= 6'(sd_init_pkg::frame_w - 1);
                end
                else if (wait_cnt == wait_w'(resp_timeout - 1))
                begin
                    hunting    <= 1'b0;
                    rx_timeout <= 1'b1;         // No answer in window
                end
                else
                    wait_cnt <= wait_cnt + 1'b1;
            end
            else if (capturing && sd_rise)
            begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == 6'd1)
                begin
                    capturing <= 1'b0;
                    rx_done   <= 1'b1;          // resp complete this cycle
                end
            end
        end
    end

    // Same shift for start bit and body, older content falls out
    always_ff @(posedge CLK)
    begin
        if (sd_rise && ((hunting && !rx_start && !cmd_in) || capturing))
            resp <= {resp[sd_init_pkg::frame_w-2:0], cmd_in};
    end

endmodule

//--- verification/sd_init_chk.sv
/*
 * Concurrent assertions on CMD line ownership and init status
 * Bound into the SD init top level
 */
`timescale 1ns/10ps

module sd_init_chk (
    input logic CLK,
    input logic rst,
    input logic cmd_in,
    input logic cmd_out,
    input logic cmd_oe,
    input logic init_done
);

    int unsigned fail_cnt = 0;                   // Failed assertion count

    // Card pulls CMD low only inside the response window
    card_in_window: assert property (@(posedge CLK) disable iff (rst) !cmd_in |-> !cmd_oe)
    else
    begin
        fail_cnt++;
        $error("Card drove CMD low while the host output was enabled");
    end

    // Host start and data zeros only with output enabled
    host_owns_start: assert property (@(posedge CLK) disable iff (rst) !cmd_out |-> cmd_oe)
    else
    begin
        fail_cnt++;
        $error("Host drove a zero on CMD with the output disabled");
    end

    // Line reclaimed at idle level
    reclaim_high: assert property (@(posedge CLK) disable iff (rst) $rose(cmd_oe) |-> cmd_out)
    else
    begin
        fail_cnt++;
        $error("Host took CMD back without driving it high");
    end

    init_done_sticky: assert property (@(posedge CLK) disable iff (rst) init_done |=> init_done)
    else
    begin
        fail_cnt++;
        $error("init_done fell after being raised");
    end

endmodule

bind sd_init_top sd_init_chk i_sd_init_chk (
    .CLK(CLK), .rst(rst), .cmd_in(cmd_in), .cmd_out(cmd_out), .cmd_oe(cmd_oe),
    .init_done(init_done)
);

//--- verification/sd_init_monitor.sv
/*
 * CMD line monitor that decodes host frames at SD clock rises
 * Compares fields with the card table, a reference CRC7 and the final OCR
 */
`timescale 1ns/10ps

module sd_init_monitor #(
    parameter int n_rows = 6                     // Expected command count
) (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     sd_clk,
    input  logic                     cmd_out,
    input  logic                     cmd_oe,
    input  logic                     init_done,
    input  sd_init_pkg::ocr_t        ocr,
    input  logic [n_rows-1:0][5:0]   exp_idx,
    input  logic [n_rows-1:0][31:0]  exp_arg,
    input  sd_init_pkg::ocr_t        exp_ocr,
    output int                       err_cnt
);

    sd_init_pkg::frame_t frame_sr;               // Bits collected MSB first
    int                  bit_cnt    = 0;         // Zero while hunting for a start bit
    int                  frame_cnt  = 0;
    int                  idle_rises = 0;         // Idle SD clocks before first command
    logic                started    = 1'b0;
    logic                done_seen  = 1'b0;

    initial
        err_cnt = 0;

    // Reference CRC7 x^7 + x^3 + 1 in register form with tap after bit 2
    function automatic logic [6:0] ref_crc7(input sd_init_pkg::frame_t f);
        logic [6:0] c;
        logic       fb;
        c = 7'h00;
        for (int i = 47; i >= 8; i--)
        begin
            fb = f[i] ^ c[6];
            c  = {c[5:3], c[2] ^ fb, c[1:0], fb};
        end
        return c;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s (frame %0d): got 0x%0h expected 0x%0h", name, frame_cnt, got,
                     exp);
            err_cnt++;
        end
    endtask

    task automatic check_frame(input sd_init_pkg::frame_t f);
        check_field("dir", f[46], 32'h1);
        check_field("end", f[0], 32'h1);
        if (frame_cnt >= n_rows)
        begin
            $display("Unexpected command %0d sent after the init sequence", f[45:40]);
            err_cnt++;
        end
        else
        begin
            check_field("index", f[45:40], exp_idx[frame_cnt]);
            check_field("arg", f[39:8], exp_arg[frame_cnt]);
            check_field("crc7", f[7:1], ref_crc7(f));
        end
        frame_cnt++;
    endtask

    always @(posedge sd_clk)
    begin
        if (bit_cnt != 0 || (cmd_oe && !cmd_out)) // Start bit or frame body
        begin
            if (!started && idle_rises < sd_init_pkg::init_clocks)
            begin
                $display("First start bit after only %0d idle SD clocks", idle_rises);
                err_cnt++;
            end
            started  = 1'b1;
            frame_sr = {frame_sr[46:0], cmd_out};
            bit_cnt++;
            if (bit_cnt == sd_init_pkg::frame_w)
            begin
                check_frame(frame_sr);
                bit_cnt = 0;
            end
        end
        else if (!started)
        begin
            if (cmd_oe && cmd_out)
                idle_rises++;
            else
            begin
                $display("CMD line not driven high during the power-up delay");
                err_cnt++;
            end
        end
    end

    // Reset values as reset is released
    always @(negedge rst)
    begin
        check_field("init_done", init_done, 32'h0);
        check_field("ocr", ocr, 32'h0);
        check_field("cmd_oe", cmd_oe, 32'h1);
        check_field("cmd_out", cmd_out, 32'h1);
    end

    // CLK domain status sampled mid-cycle
    always @(negedge CLK)
    begin
        if (!rst && init_done && !done_seen)
        begin
            done_seen = 1'b1;
            check_field("ocr", ocr, exp_ocr);
            if (frame_cnt != n_rows)
            begin
                $display("init_done raised after %0d commands instead of %0d", frame_cnt, n_rows);
                err_cnt++;
            end
        end
    end

endmodule

//--- verification/tb_sd_init.sv
/*
 * Testbench for SD card init: clock, reset, card model driven from a
 * response table, CMD line monitor and run timeout
 */
`timescale 1ns/10ps

module tb_sd_init;

    localparam int          half_div     = 2;
    localparam int          resp_timeout = 64;
    localparam int          n_rows       = 6;
    localparam int          cmd_clocks   = 48 + 64 + 48 + 60;  // Worst case per command
    localparam int          post_clocks  = 200;                // Quiet window after init
    localparam int          run_limit    = (2 * (n_rows * cmd_clocks + 80) + post_clocks)
                                           * 2 * half_div;     // CLK cycles, 2x margin
    localparam logic [31:0] lfsr_seed    = 32'h60f2;
    localparam logic [31:0] lfsr_taps    = 32'h8020_0003;      // x^32+x^22+x^2+x+1

    logic                    CLK;
    logic                    rst;
    logic                    cmd_in;
    logic                    sd_clk;
    logic                    cmd_out;
    logic                    cmd_oe;
    logic                    init_done;
    sd_init_pkg::ocr_t       ocr;
    logic                    card_drive;                       // Card owns CMD
    logic                    card_bit;
    logic [n_rows-1:0][5:0]  exp_idx;                          // Expected command index
    logic [n_rows-1:0][31:0] exp_arg;
    logic [n_rows-1:0]       row_answer;                       // Card replies to this row
    sd_init_pkg::frame_t     row_resp [n_rows];
    sd_init_pkg::ocr_t       exp_ocr;
    logic [31:0]             lfsr;
    int unsigned             cycle_cnt = 0;
    int                      mon_errors;

    assign cmd_in = card_drive ? card_bit : 1'b1;              // Pull-up on CMD

    sd_init_top #(.half_div(half_div), .resp_timeout(resp_timeout)) i_sd_init_top (
        .CLK(CLK), .rst(rst), .cmd_in(cmd_in), .sd_clk(sd_clk), .cmd_out(cmd_out),
        .cmd_oe(cmd_oe), .init_done(init_done), .ocr(ocr)
    );

    sd_init_monitor #(.n_rows(n_rows)) i_sd_init_monitor (
        .CLK(CLK), .rst(rst), .sd_clk(sd_clk), .cmd_out(cmd_out), .cmd_oe(cmd_oe),
        .init_done(init_done), .ocr(ocr), .exp_idx(exp_idx), .exp_arg(exp_arg),
        .exp_ocr(exp_ocr), .err_cnt(mon_errors)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);       // Galois, right shift
    endfunction

    task automatic set_row(input int r, input logic [5:0] idx, input logic [31:0] arg,
                           input logic ans, input sd_init_pkg::frame_t resp);
        exp_idx[r]    = idx;
        exp_arg[r]    = arg;
        row_answer[r] = ans;
        row_resp[r]   = resp;
    endtask

    // Card shifts its answer out on SD clock falls, host samples on rises
    task automatic send_response(input sd_init_pkg::frame_t f);
        repeat (8) @(negedge sd_clk);                          // Turnaround before start bit
        for (int b = 47; b >= 0; b--)
        begin
            #1;
            card_drive = 1'b1;
            card_bit   = f[b];
            @(negedge sd_clk);
        end
        #1;
        card_drive = 1'b0;
        card_bit   = 1'b1;
    endtask

    task automatic report_counts;
        $display("Errors: %0d monitor, %0d assertion, after %0d CLK cycles", mon_errors,
                 i_sd_init_top.i_sd_init_chk.fail_cnt, cycle_cnt);
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial
    begin
        rst        = 1'b1;
        card_drive = 1'b0;
        card_bit   = 1'b1;
        lfsr       = lfsr_seed;
        for (int i = 0; i < 32; i++)                            // One step per OCR bit
        begin
            exp_ocr[i] = lfsr[0];
            lfsr       = lfsr_step(lfsr);
        end
        exp_ocr[31] = 1'b1;                                     // Power-up done
        // Response CRC fields are left zero, the host ignores them
        set_row(0, 6'd0, 32'h0000_0000, 1'b0, '1);                                      // Silent
        set_row(1, 6'd8, 32'h0000_01AA, 1'b1, {2'b00, 6'd8, 32'h0000_01AA, 7'h00, 1'b1}); // R7
        set_row(2, 6'd55, 32'h0000_0000, 1'b1, {2'b00, 6'd55, 32'h0000_0120, 7'h00, 1'b1});
        set_row(3, 6'd41, 32'h4010_0000, 1'b1, {2'b00, 6'h3f, 32'h00FF_8000, 7'h7f, 1'b1}); // Busy
        set_row(4, 6'd55, 32'h0000_0000, 1'b1, {2'b00, 6'd55, 32'h0000_0120, 7'h00, 1'b1});
        set_row(5, 6'd41, 32'h4010_0000, 1'b1, {2'b00, 6'h3f, exp_ocr, 7'h7f, 1'b1});
        repeat (10) @(posedge CLK);
        #1 rst = 1'b0;
        wait (init_done === 1'b1);
        repeat (post_clocks * 2 * half_div) @(posedge CLK);    // No frame may follow
        report_counts();
        if (mon_errors == 0 && i_sd_init_top.i_sd_init_chk.fail_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Card model, one table row per host command
    initial
    begin : card_model
        @(negedge rst);
        for (int r = 0; r < n_rows; r++)
        begin
            @(negedge cmd_oe);                                  // Command sent, line released
            if (row_answer[r])
                send_response(row_resp[r]);
            @(posedge cmd_oe);
        end
    end

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == run_limit)
        begin
            $display("Timeout: init sequence did not finish within %0d CLK cycles", run_limit);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule
